//--- include/axil_reg_defs.svh
// --------------------------------------
// AXI-Lite register slave sizes
// bus widths, slot count, timeout and the identification constant
// --------------------------------------
`ifndef AXIL_REG_DEFS_SVH
`define AXIL_REG_DEFS_SVH

// AXI-Lite data bus width in bits
`define AXIL_DATA_W 32

// byte address width, covers the eight word slots with room to spare
`define AXIL_ADDR_W 8

// one write strobe per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// number of decoded word slots in the bank
`define REG_COUNT 8

// strobe cycles without wait before an unanswered transaction is ended
`define REG_TIMEOUT 4

// constant returned by the identification register
`define REG_ID_VALUE 32'h41C0_0107

`endif

//--- hw/axil_reg_pkg.sv
// --------------------------------------
// AXI-Lite register slave package
// response encoding and the register slot names
// --------------------------------------
`include "axil_reg_defs.svh"

package axil_reg_pkg;

    // AXI response codes, this slave only ever answers OKAY
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;

    // word index into the bank, taken from the address above the byte offset
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // slot map, the last index has no register behind it
    localparam reg_idx_t SCRATCH0 = reg_idx_t'(0);
    localparam reg_idx_t SCRATCH1 = reg_idx_t'(1);
    localparam reg_idx_t SCRATCH2 = reg_idx_t'(2);
    localparam reg_idx_t SCRATCH3 = reg_idx_t'(3);
    localparam reg_idx_t ID_REG   = reg_idx_t'(4);
    localparam reg_idx_t WR_COUNT = reg_idx_t'(5);
    localparam reg_idx_t SLOW_REG = reg_idx_t'(6);

endpackage

//--- hw/reg_bus_if.sv
// --------------------------------------
// register bus interfaces
// simple strobe buses between the AXI-Lite front ends and the bank
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

// write side, one strobe carries address, data and byte enables
interface reg_wr_bus;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;
    logic                    en;
    // the bank holds the transfer off with this level
    logic                    wait_req;
    // combinational answer from the bank, valid only while en is high
    logic                    ack;

    modport wr_src (
        output addr, data, strb, en,
        input  wait_req, ack
    );

    modport wr_sink (
        input  addr, data, strb, en,
        output wait_req, ack
    );
endinterface

// read side, data comes back from the bank in the ack cycle
interface reg_rd_bus;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic                    en;
    logic [`AXIL_DATA_W-1:0] data;
    logic                    wait_req;
    logic                    ack;

    modport rd_src (
        output addr, en,
        input  data, wait_req, ack
    );

    modport rd_sink (
        input  addr, en,
        output data, wait_req, ack
    );
endinterface

//--- hw/axil_reg_wr.sv
// --------------------------------------
// AXI-Lite write front end
// captures aw and w, drives the register write strobe and
// answers on b, ending on ack or on timeout
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

module axil_reg_wr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic [2:0]                awprot,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_STRB_W-1:0]   wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output axil_reg_pkg::axil_resp_t  bresp,
    output logic                      bvalid,
    input  logic                      bready,
    reg_wr_bus.wr_src                 wr
);
    import axil_reg_pkg::*;

    localparam int TO_W = $clog2(`REG_TIMEOUT);

    logic [TO_W-1:0]         to_cnt, to_cnt_next;
    logic [`AXIL_ADDR_W-1:0] addr_q, addr_next;
    logic [`AXIL_DATA_W-1:0] data_q, data_next;
    logic [`AXIL_STRB_W-1:0] strb_q, strb_next;
    logic                    aw_full, aw_full_next;
    logic                    w_full, w_full_next;
    logic                    bvalid_q, bvalid_next;
    logic                    en_q, en_next;
    logic                    done;

    // a channel is ready whenever its holding register is empty
    assign awready = !aw_full;
    assign wready  = !w_full;
    assign bresp   = OKAY;
    assign bvalid  = bvalid_q;

    assign wr.addr = addr_q;
    assign wr.data = data_q;
    assign wr.strb = strb_q;
    assign wr.en   = en_q;

    // the strobe ends when the bank answers or the count has run out
    assign done = en_q && (wr.ack || to_cnt == '0);

    always_comb begin
        to_cnt_next  = to_cnt;
        addr_next    = addr_q;
        aw_full_next = aw_full;
        data_next    = data_q;
        strb_next    = strb_q;
        w_full_next  = w_full;
        bvalid_next  = bvalid_q;

        if (done) begin
            bvalid_next = 1'b1;
        end

        // holding registers stay full until the response is taken,
        // so a following write waits behind a stalled b channel
        if (bvalid_q && bready) begin
            bvalid_next  = 1'b0;
            aw_full_next = 1'b0;
            w_full_next  = 1'b0;
        end

        // the timeout restarts with every fresh address
        if (!aw_full) begin
            addr_next    = awaddr;
            aw_full_next = awvalid;
            to_cnt_next  = TO_W'(`REG_TIMEOUT - 1);
        end

        if (!w_full) begin
            data_next   = wdata;
            strb_next   = wstrb;
            w_full_next = wvalid;
        end

        // wait from the bank freezes the count
        if (en_q && !wr.wait_req && to_cnt != '0) begin
            to_cnt_next = to_cnt - 1'b1;
        end

        en_next = aw_full_next && w_full_next && !bvalid_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            to_cnt   <= '0;
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
            bvalid_q <= 1'b0;
            en_q     <= 1'b0;
        end else begin
            to_cnt   <= to_cnt_next;
            aw_full  <= aw_full_next;
            w_full   <= w_full_next;
            bvalid_q <= bvalid_next;
            en_q     <= en_next;
        end
    end

    // payload follows its full flag
    always_ff @(posedge clk) begin
        addr_q <= addr_next;
        data_q <= data_next;
        strb_q <= strb_next;
    end

endmodule

//--- hw/axil_reg_rd.sv
// --------------------------------------
// AXI-Lite read front end
// holds ar, drives the register read strobe and returns
// bank data on r, or zero after a timeout
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

module axil_reg_rd (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic [2:0]                arprot,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output axil_reg_pkg::axil_resp_t  rresp,
    output logic                      rvalid,
    input  logic                      rready,
    reg_rd_bus.rd_src                 rd
);
    import axil_reg_pkg::*;

    localparam int TO_W = $clog2(`REG_TIMEOUT);

    logic [TO_W-1:0]         to_cnt, to_cnt_next;
    logic [`AXIL_ADDR_W-1:0] addr_q, addr_next;
    logic [`AXIL_DATA_W-1:0] rdata_q, rdata_next;
    logic                    ar_full, ar_full_next;
    logic                    rvalid_q, rvalid_next;
    logic                    en_q, en_next;
    logic                    done;

    assign arready = !ar_full;
    assign rdata   = rdata_q;
    assign rresp   = OKAY;
    assign rvalid  = rvalid_q;

    assign rd.addr = addr_q;
    assign rd.en   = en_q;

    assign done = en_q && (rd.ack || to_cnt == '0);

    always_comb begin
        to_cnt_next  = to_cnt;
        addr_next    = addr_q;
        ar_full_next = ar_full;
        rdata_next   = rdata_q;
        rvalid_next  = rvalid_q;

        // an unanswered read returns zero
        if (done) begin
            rvalid_next = 1'b1;
            rdata_next  = rd.ack ? rd.data : '0;
        end

        // the address register is released only with the r handshake
        if (rvalid_q && rready) begin
            rvalid_next  = 1'b0;
            ar_full_next = 1'b0;
        end

        if (!ar_full) begin
            addr_next    = araddr;
            ar_full_next = arvalid;
            to_cnt_next  = TO_W'(`REG_TIMEOUT - 1);
        end

        if (en_q && !rd.wait_req && to_cnt != '0) begin
            to_cnt_next = to_cnt - 1'b1;
        end

        en_next = ar_full_next && !rvalid_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            to_cnt   <= '0;
            ar_full  <= 1'b0;
            rvalid_q <= 1'b0;
            en_q     <= 1'b0;
        end else begin
            to_cnt   <= to_cnt_next;
            ar_full  <= ar_full_next;
            rvalid_q <= rvalid_next;
            en_q     <= en_next;
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= addr_next;
        rdata_q <= rdata_next;
    end

endmodule

//--- hw/reg_bank.sv
// --------------------------------------
// register bank
// decodes both register buses, stores byte-strobed writes,
// counts writes and stretches slow-register accesses with wait
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

module reg_bank (
    input  logic       clk,
    input  logic       rst,
    reg_wr_bus.wr_sink wr,
    reg_rd_bus.rd_sink rd
);
    import axil_reg_pkg::*;

    localparam int IDX_W     = $bits(reg_idx_t);
    // en cycles the slow register holds wait before it answers
    localparam int SLOW_WAIT = 2;

    logic [`AXIL_DATA_W-1:0] scratch [4];
    logic [`AXIL_DATA_W-1:0] slow_q;
    logic [`AXIL_DATA_W-1:0] wr_count;
    logic [`AXIL_DATA_W-1:0] rd_word;
    logic [1:0]              wr_slow_cnt;
    logic [1:0]              rd_slow_cnt;
    reg_idx_t                wr_idx;
    reg_idx_t                rd_idx;

    // replace only the bytes whose strobe is set
    function automatic logic [`AXIL_DATA_W-1:0] merge_bytes(
        input logic [`AXIL_DATA_W-1:0] old_word,
        input logic [`AXIL_DATA_W-1:0] new_word,
        input logic [`AXIL_STRB_W-1:0] strb
    );
        logic [`AXIL_DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < `AXIL_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // word index sits just above the byte offset
    assign wr_idx = wr.addr[IDX_W+1:2];
    assign rd_idx = rd.addr[IDX_W+1:2];

    // ---------------------------------------
    // handshake
    // ---------------------------------------

    // slow slot holds wait until its counter has seen enough en cycles
    assign wr.wait_req = wr.en && wr_idx == SLOW_REG && wr_slow_cnt != 2'(SLOW_WAIT);
    assign rd.wait_req = rd.en && rd_idx == SLOW_REG && rd_slow_cnt != 2'(SLOW_WAIT);

    // slots above SLOW_REG have no register and never answer
    assign wr.ack = wr.en && wr_idx <= SLOW_REG && !wr.wait_req;
    assign rd.ack = rd.en && rd_idx <= SLOW_REG && !rd.wait_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_slow_cnt <= '0;
            rd_slow_cnt <= '0;
        end else begin
            wr_slow_cnt <= wr.wait_req ? wr_slow_cnt + 1'b1 : '0;
            rd_slow_cnt <= rd.wait_req ? rd_slow_cnt + 1'b1 : '0;
        end
    end

    // ---------------------------------------
    // storage
    // ---------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                scratch[i] <= '0;
            end
            slow_q   <= '0;
            wr_count <= '0;
        end else if (wr.en && wr.ack) begin
            // every answered write counts, read-only slots included
            wr_count <= wr_count + 1'b1;
            case (wr_idx)
                SCRATCH0, SCRATCH1, SCRATCH2, SCRATCH3: begin
                    scratch[wr_idx[1:0]] <= merge_bytes(scratch[wr_idx[1:0]], wr.data,
                                                        wr.strb);
                end
                SLOW_REG: slow_q <= merge_bytes(slow_q, wr.data, wr.strb);
                // ID_REG and WR_COUNT take the ack and keep their value
                default: ;
            endcase
        end
    end

    // read mux
    always_comb begin
        case (rd_idx)
            SCRATCH0, SCRATCH1, SCRATCH2, SCRATCH3: rd_word = scratch[rd_idx[1:0]];
            ID_REG:   rd_word = `REG_ID_VALUE;
            WR_COUNT: rd_word = wr_count;
            SLOW_REG: rd_word = slow_q;
            default:  rd_word = '0;
        endcase
    end

    // data is presented only in the answered cycle
    assign rd.data = (rd.en && rd.ack) ? rd_word : '0;

endmodule

//--- hw/axil_reg_top.sv
// --------------------------------------
// AXI-Lite register slave top level
// write and read front ends feeding one register bank
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

module axil_reg_top (
    input  logic                      clk,
    input  logic                      rst,
    // write address and data channels
    input  logic [`AXIL_ADDR_W-1:0]   s_axil_awaddr,
    input  logic [2:0]                s_axil_awprot,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,
    input  logic [`AXIL_DATA_W-1:0]   s_axil_wdata,
    input  logic [`AXIL_STRB_W-1:0]   s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,
    // write response
    output axil_reg_pkg::axil_resp_t  s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,
    // read address and data channels
    input  logic [`AXIL_ADDR_W-1:0]   s_axil_araddr,
    input  logic [2:0]                s_axil_arprot,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,
    output logic [`AXIL_DATA_W-1:0]   s_axil_rdata,
    output axil_reg_pkg::axil_resp_t  s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready
);

    // front end stage to bank stage
    reg_wr_bus wr_bus ();
    reg_rd_bus rd_bus ();

    axil_reg_wr u_axil_reg_wr (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (s_axil_awaddr),
        .awprot  (s_axil_awprot),
        .awvalid (s_axil_awvalid),
        .awready (s_axil_awready),
        .wdata   (s_axil_wdata),
        .wstrb   (s_axil_wstrb),
        .wvalid  (s_axil_wvalid),
        .wready  (s_axil_wready),
        .bresp   (s_axil_bresp),
        .bvalid  (s_axil_bvalid),
        .bready  (s_axil_bready),
        .wr      (wr_bus.wr_src)
    );

    axil_reg_rd u_axil_reg_rd (
        .clk     (clk),
        .rst     (rst),
        .araddr  (s_axil_araddr),
        .arprot  (s_axil_arprot),
        .arvalid (s_axil_arvalid),
        .arready (s_axil_arready),
        .rdata   (s_axil_rdata),
        .rresp   (s_axil_rresp),
        .rvalid  (s_axil_rvalid),
        .rready  (s_axil_rready),
        .rd      (rd_bus.rd_src)
    );

    reg_bank u_reg_bank (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.wr_sink),
        .rd  (rd_bus.rd_sink)
    );

endmodule

//--- dv/tb_clk_gen.sv
// --------------------------------------
// testbench clock and reset source
// 4 ns clock, reset held high for the first three cycles
// --------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset drops on the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- dv/axil_reg_chk.sv
// --------------------------------------
// AXI-Lite register slave handshake checker
// response hold, strobe exclusion and post-reset ready levels
// --------------------------------------
`timescale 1ns/1ps

module axil_reg_chk (
    input logic clk,
    input logic rst,
    input logic awready,
    input logic wready,
    input logic arready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic wr_en,
    input logic rd_en
);

    // a response may only leave through its handshake
    a_b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped while bready was low");

    a_r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped while rready was low");

    // the register strobe is over once the response is pending
    a_wr_en_excl: assert property (@(posedge clk) disable iff (rst) !(wr_en && bvalid))
        else $error("write strobe high while bvalid is high");

    a_rd_en_excl: assert property (@(posedge clk) disable iff (rst) !(rd_en && rvalid))
        else $error("read strobe high while rvalid is high");

    // every holding register is empty right after a reset cycle
    a_rst_ready: assert property (@(posedge clk) rst |=> awready && wready && arready)
        else $error("address or data channel not ready after reset");

    a_rst_idle: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
        else $error("response valid right after reset");

endmodule

//--- dv/tb_axil_reg.sv
// --------------------------------------
// AXI-Lite register slave testbench
// directed tests against a slot model, with AXI-Lite driver tasks
// --------------------------------------
`timescale 1ns/1ps
`include "axil_reg_defs.svh"

module tb_axil_reg;
    import axil_reg_pkg::*;

    // upper bound on transactions issued by all tests together
    localparam int TXN_COUNT   = 64;
    // accept, timeout, hold and release cycles of the slowest transaction
    localparam int WORST_LAT   = 20;
    localparam int CYCLE_LIMIT = TXN_COUNT * WORST_LAT + 100;
    localparam reg_idx_t UNMAPPED = reg_idx_t'(7);

    logic                     clk;
    logic                     rst;
    logic [`AXIL_ADDR_W-1:0]  awaddr;
    logic [2:0]               awprot;
    logic                     awvalid;
    logic                     awready;
    logic [`AXIL_DATA_W-1:0]  wdata;
    logic [`AXIL_STRB_W-1:0]  wstrb;
    logic                     wvalid;
    logic                     wready;
    axil_resp_t               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`AXIL_ADDR_W-1:0]  araddr;
    logic [2:0]               arprot;
    logic                     arvalid;
    logic                     arready;
    logic [`AXIL_DATA_W-1:0]  rdata;
    axil_resp_t               rresp;
    logic                     rvalid;
    logic                     rready;

    logic [`AXIL_DATA_W-1:0]  model [`REG_COUNT];
    logic [`AXIL_DATA_W-1:0]  write_total;
    logic [31:0]              rng_state = 32'd52603;
    string                    test_name = "none";
    int                       cycle = 0;
    int                       accept_cycle = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    axil_reg_top u_axil_reg_top (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awaddr  (awaddr),
        .s_axil_awprot  (awprot),
        .s_axil_awvalid (awvalid),
        .s_axil_awready (awready),
        .s_axil_wdata   (wdata),
        .s_axil_wstrb   (wstrb),
        .s_axil_wvalid  (wvalid),
        .s_axil_wready  (wready),
        .s_axil_bresp   (bresp),
        .s_axil_bvalid  (bvalid),
        .s_axil_bready  (bready),
        .s_axil_araddr  (araddr),
        .s_axil_arprot  (arprot),
        .s_axil_arvalid (arvalid),
        .s_axil_arready (arready),
        .s_axil_rdata   (rdata),
        .s_axil_rresp   (rresp),
        .s_axil_rvalid  (rvalid),
        .s_axil_rready  (rready)
    );

    bind axil_reg_top axil_reg_chk u_axil_reg_chk (
        .clk     (clk),
        .rst     (rst),
        .awready (s_axil_awready),
        .wready  (s_axil_wready),
        .arready (s_axil_arready),
        .bvalid  (s_axil_bvalid),
        .bready  (s_axil_bready),
        .rvalid  (s_axil_rvalid),
        .rready  (s_axil_rready),
        .wr_en   (wr_bus.en),
        .rd_en   (rd_bus.en)
    );

    // the counter also bounds every wait loop below
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("ERROR: simulation timed out after %0d cycles waiting on the DUT", cycle);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [`AXIL_ADDR_W-1:0] addr_of(input reg_idx_t idx);
        return `AXIL_ADDR_W'({idx, 2'b00});
    endfunction

    // plain slots answer two cycles after acceptance and the slow slot after four
    function automatic int latency_of(input reg_idx_t idx);
        if (idx == UNMAPPED) begin
            return 0;
        end
        return (idx == SLOW_REG) ? 4 : 2;
    endfunction

    // apply one acknowledged write to the model with bytes masked by strobe
    function automatic void model_write(input reg_idx_t idx, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic [31:0] mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        if (idx != UNMAPPED) begin
            write_total = write_total + 1;
            if (idx != ID_REG && idx != WR_COUNT) begin
                model[idx] = (model[idx] & ~mask) | (data & mask);
            end
        end
    endfunction

    function automatic logic [31:0] expected_read(input reg_idx_t idx);
        case (idx)
            ID_REG:   return `REG_ID_VALUE;
            WR_COUNT: return write_total;
            UNMAPPED: return '0;
            default:  return model[idx];
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: test %s, %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ----------------------------------------
    // AXI-Lite driver
    // ----------------------------------------

    task automatic put_write(input reg_idx_t idx, input logic [31:0] data,
                             input logic [3:0] strb);
        @(posedge clk);
        awaddr  <= addr_of(idx);
        awprot  <= 3'b010;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
    endtask

    // aw and w may be taken on different edges
    task automatic wait_write_accept();
        logic aw_done;
        logic w_done;
        logic aw_hs;
        logic w_hs;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_hs = !aw_done && awready;
            w_hs  = !w_done && wready;
            if (aw_hs || w_hs) begin
                accept_cycle = cycle;
            end
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
    endtask

    // hold keeps bready low for extra cycles and checks that nothing moves
    task automatic take_write_resp(input int exp_lat, input int hold);
        do @(negedge clk); while (!bvalid);
        if (exp_lat > 0) begin
            check_value("write latency", exp_lat, cycle - accept_cycle);
        end
        check_value("bresp", 32'(OKAY), 32'(bresp));
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("bvalid held", 32'd1, 32'(bvalid));
            check_value("bresp held", 32'(OKAY), 32'(bresp));
            check_value("awready while response pending", 32'd0, 32'(awready));
            check_value("wready while response pending", 32'd0, 32'(wready));
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_write(input reg_idx_t idx, input logic [31:0] data,
                              input logic [3:0] strb);
        put_write(idx, data, strb);
        wait_write_accept();
        take_write_resp(latency_of(idx), 0);
        model_write(idx, data, strb);
    endtask

    task automatic axil_read(input reg_idx_t idx, input int hold, output logic [31:0] data);
        int acc;
        @(posedge clk);
        araddr  <= addr_of(idx);
        arprot  <= 3'b010;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        acc = cycle;
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        if (latency_of(idx) > 0) begin
            check_value("read latency", latency_of(idx), cycle - acc);
        end
        check_value("rresp", 32'(OKAY), 32'(rresp));
        data = rdata;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("rvalid held", 32'd1, 32'(rvalid));
            check_value("rdata held", expected_read(idx), rdata);
            check_value("arready while response pending", 32'd0, 32'(arready));
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic read_check(input reg_idx_t idx, input int hold);
        logic [31:0] data;
        axil_read(idx, hold, data);
        check_value($sformatf("read of slot %0d", idx), expected_read(idx), data);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic test_reset_values();
        test_name = "reset_values";
        for (int i = 0; i < 7; i++) begin
            read_check(reg_idx_t'(i), 0);
        end
    endtask

    task automatic test_scratch_full();
        test_name = "scratch_full";
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 4; i++) begin
                axil_write(reg_idx_t'(i), next_rand(), 4'hF);
            end
            for (int i = 0; i < 4; i++) begin
                read_check(reg_idx_t'(i), 0);
            end
        end
    endtask

    task automatic test_partial_strobe();
        logic [31:0] r;
        test_name = "partial_strobe";
        for (int n = 0; n < 8; n++) begin
            r = next_rand();
            axil_write(reg_idx_t'(n % 4), next_rand(), r[3:0]);
            read_check(reg_idx_t'(n % 4), 0);
        end
    endtask

    task automatic test_slow_and_readonly();
        test_name = "slow_and_readonly";
        axil_write(SLOW_REG, next_rand(), 4'hF);
        read_check(SLOW_REG, 0);
        axil_write(SLOW_REG, next_rand(), 4'b1010);
        read_check(SLOW_REG, 0);
        // read-only slots take the write and keep their value
        axil_write(ID_REG, next_rand(), 4'hF);
        read_check(ID_REG, 0);
        axil_write(WR_COUNT, next_rand(), 4'hF);
        read_check(WR_COUNT, 0);
    endtask

    task automatic test_unmapped();
        test_name = "unmapped";
        axil_write(UNMAPPED, next_rand(), 4'hF);
        read_check(UNMAPPED, 0);
        read_check(WR_COUNT, 0);
    endtask

    task automatic test_back_pressure();
        logic [31:0] first_word;
        logic [31:0] second_word;
        test_name   = "back_pressure";
        first_word  = next_rand();
        second_word = next_rand();
        put_write(SCRATCH1, first_word, 4'hF);
        wait_write_accept();
        // the second write waits behind the stalled b channel
        put_write(SCRATCH1, second_word, 4'b0110);
        take_write_resp(2, 6);
        model_write(SCRATCH1, first_word, 4'hF);
        wait_write_accept();
        take_write_resp(2, 0);
        model_write(SCRATCH1, second_word, 4'b0110);
        read_check(SCRATCH1, 6);
        read_check(WR_COUNT, 0);
    endtask

    initial begin
        awaddr  <= '0;
        awprot  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arprot  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        write_total = '0;

        do @(negedge clk); while (rst);

        test_reset_values();
        test_scratch_full();
        test_partial_strobe();
        test_slow_and_readonly();
        test_unmapped();
        test_back_pressure();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- axil_reg_top.f
+incdir+include
hw/axil_reg_pkg.sv
hw/reg_bus_if.sv
hw/axil_reg_wr.sv
hw/axil_reg_rd.sv
hw/reg_bank.sv
hw/axil_reg_top.sv
dv/tb_clk_gen.sv
dv/axil_reg_chk.sv
dv/tb_axil_reg.sv

//--- Makefile
# Verilator build and run for the AXI-Lite register slave

VERILATOR ?= verilator
TOP       ?= tb_axil_reg
RTL_TOP   ?= axil_reg_top
FILELIST  ?= axil_reg_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
